// ==== hw/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Sizes
`define IMEM_WORDS 32
`define DMEM_WORDS 8
`define REG_COUNT  8
`define DWORD      32
`define NB_STATE   3

`define OP_RTYPE   6'h00
`define OP_ADDIU   6'h09
`define OP_LW      6'h23
`define OP_SW      6'h2b
`define OP_BEQ     6'h04
`define OP_HALT    6'h3f

// R-type function field, also used as ALU operation
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a

`define CMD_LOAD   8'h4c  // 'L'
`define CMD_RUN    8'h52  // 'R'
`define CMD_STEP   8'h53  // 'S'
`define CMD_DUMP   8'h44  // 'D'

`endif

// ==== hw/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same instruction word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        logic [5:0]        alu_op;   // Function code
        logic              alu_imm;  // Operand b is the immediate
        logic              reg_we;
        logic              mem_rd;
        logic              mem_wr;
        logic              branch;
        logic              halt;
        logic [4:0]        rd;
        logic [`DWORD-1:0] imm;
        logic [`DWORD-1:0] rs_val;
        logic [`DWORD-1:0] rt_val;
    } ctrl_t;

    typedef struct packed {
        logic [`DWORD-1:0] alu_result;
        logic [`DWORD-1:0] store_data;
        logic [`DWORD-1:0] next_pc;
        logic              reg_we;
        logic              mem_rd;
        logic              mem_wr;
        logic [4:0]        rd;
    } exec_t;

    typedef struct packed {
        logic              we;
        logic [4:0]        addr;
        logic [`DWORD-1:0] data;
    } wb_t;

    typedef enum logic [`NB_STATE-1:0] {
        IDLE,
        LOAD_COUNT,
        LOAD_BYTES,
        RUN,
        DUMP
    } du_state_e;

endpackage

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module instr_decode
    import cpu_pkg::*;
(
    input  logic                           i_clock,
    input  logic                           i_arst_n,
    input  logic                           i_cpu_en,
    input  logic                           i_clear,
    input  logic                           i_im_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0] i_im_addr,
    input  logic [`DWORD-1:0]              i_im_data,
    input  logic [`DWORD-1:0]              i_next_pc,
    input  wb_t                            i_wb,
    input  logic [$clog2(`REG_COUNT)-1:0]  i_dbg_reg_addr,
    output ctrl_t                          o_ctrl,
    output logic [`DWORD-1:0]              o_pc,
    output logic [`DWORD-1:0]              o_dbg_reg_data
);
    localparam int IM_AW = $clog2(`IMEM_WORDS);
    localparam int RF_AW = $clog2(`REG_COUNT);

    logic [`DWORD-1:0] pc_q;
    logic [`DWORD-1:0] imem [`IMEM_WORDS];
    logic [`DWORD-1:0] regs [`REG_COUNT];
    instr_u            instr;

    // Register 0 reads as zero
    function automatic logic [`DWORD-1:0] read_reg(input logic [RF_AW-1:0] idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= '0;
        end else if (i_clear) begin
            pc_q <= '0;
        end else if (i_cpu_en) begin
            pc_q <= i_next_pc;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_im_we) begin
            imem[i_im_addr] <= i_im_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (i_clear) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (i_cpu_en && i_wb.we) begin
            regs[i_wb.addr[RF_AW-1:0]] <= i_wb.data;
        end
    end

    assign instr          = imem[pc_q[IM_AW-1:0]];
    assign o_pc           = pc_q;
    assign o_dbg_reg_data = read_reg(i_dbg_reg_addr);

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.imm    = {{(`DWORD-16){instr.i.imm[15]}}, instr.i.imm};
        o_ctrl.rs_val = read_reg(instr.r.rs[RF_AW-1:0]);
        o_ctrl.rt_val = read_reg(instr.r.rt[RF_AW-1:0]);
        o_ctrl.alu_op = `FN_ADDU;  // Address and ADDIU sums
        case (instr.r.opcode)
            `OP_RTYPE: begin
                o_ctrl.alu_op = instr.r.funct;
                o_ctrl.reg_we = 1'b1;
                o_ctrl.rd     = instr.r.rd;
            end
            `OP_ADDIU: begin
                o_ctrl.alu_imm = 1'b1;
                o_ctrl.reg_we  = 1'b1;
                o_ctrl.rd      = instr.i.rt;
            end
            `OP_LW: begin
                o_ctrl.alu_imm = 1'b1;
                o_ctrl.reg_we  = 1'b1;
                o_ctrl.mem_rd  = 1'b1;
                o_ctrl.rd      = instr.i.rt;
            end
            `OP_SW: begin
                o_ctrl.alu_imm = 1'b1;
                o_ctrl.mem_wr  = 1'b1;
            end
            `OP_BEQ: begin
                o_ctrl.alu_op = `FN_SUBU;
                o_ctrl.branch = 1'b1;
            end
            `OP_HALT: o_ctrl.halt = 1'b1;
            default: ;  // Unknown opcode is a no-op
        endcase
    end

endmodule

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu_execute
    import cpu_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_arst_n,
    input  logic              i_cpu_en,
    input  logic              i_clear,
    input  ctrl_t             i_ctrl,
    input  logic [`DWORD-1:0] i_pc,
    output exec_t             o_exec,
    output logic [`DWORD-1:0] o_next_pc,
    output logic              o_hlt
);
    logic [`DWORD-1:0] op_b;
    logic [`DWORD-1:0] alu_out;
    logic [`DWORD-1:0] pc_inc;
    logic              taken;
    logic              hlt_q;

    assign op_b = i_ctrl.alu_imm ? i_ctrl.imm : i_ctrl.rt_val;

    always_comb begin
        case (i_ctrl.alu_op)
            `FN_ADDU: alu_out = i_ctrl.rs_val + op_b;
            `FN_SUBU: alu_out = i_ctrl.rs_val - op_b;
            `FN_AND:  alu_out = i_ctrl.rs_val & op_b;
            `FN_OR:   alu_out = i_ctrl.rs_val | op_b;
            `FN_XOR:  alu_out = i_ctrl.rs_val ^ op_b;
            `FN_SLT:  alu_out = {{(`DWORD-1){1'b0}}, $signed(i_ctrl.rs_val) < $signed(op_b)};
            default:  alu_out = '0;
        endcase
    end

    // Branch offset counts words from PC + 1
    assign pc_inc    = i_pc + 1'b1;
    assign taken     = i_ctrl.branch && (i_ctrl.rs_val == i_ctrl.rt_val);
    assign o_next_pc = i_ctrl.halt ? i_pc : (taken ? pc_inc + i_ctrl.imm : pc_inc);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hlt_q <= 1'b0;
        end else if (i_clear) begin
            hlt_q <= 1'b0;
        end else if (i_cpu_en && i_ctrl.halt) begin
            hlt_q <= 1'b1;
        end
    end

    assign o_hlt = hlt_q;

    always_comb begin
        o_exec.alu_result = alu_out;
        o_exec.store_data = i_ctrl.rt_val;
        o_exec.next_pc    = o_next_pc;
        o_exec.reg_we     = i_ctrl.reg_we;
        o_exec.mem_rd     = i_ctrl.mem_rd;
        o_exec.mem_wr     = i_ctrl.mem_wr;
        o_exec.rd         = i_ctrl.rd;
    end

endmodule

// ==== hw/mem_result.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module mem_result
    import cpu_pkg::*;
(
    input  logic                           i_clock,
    input  logic                           i_arst_n,
    input  logic                           i_cpu_en,
    input  logic                           i_clear,
    input  exec_t                          i_exec,
    input  logic [$clog2(`DMEM_WORDS)-1:0] i_dbg_mem_addr,
    output wb_t                            o_wb,
    output logic [`DWORD-1:0]              o_dbg_mem_data
);
    localparam int DM_AW = $clog2(`DMEM_WORDS);

    logic [`DWORD-1:0] dmem [`DMEM_WORDS];
    logic [DM_AW-1:0]  addr;

    assign addr = i_exec.alu_result[DM_AW-1:0];  // Word address, upper bits ignored

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int k = 0; k < `DMEM_WORDS; k++) begin
                dmem[k] <= '0;
            end
        end else if (i_clear) begin
            for (int k = 0; k < `DMEM_WORDS; k++) begin
                dmem[k] <= '0;
            end
        end else if (i_cpu_en && i_exec.mem_wr) begin
            dmem[addr] <= i_exec.store_data;
        end
    end

    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    // Load data or ALU result back to the register file
    always_comb begin
        o_wb.we   = i_exec.reg_we;
        o_wb.addr = i_exec.rd;
        if (i_exec.mem_rd) begin
            o_wb.data = dmem[addr];
        end else begin
            o_wb.data = i_exec.alu_result;
        end
    end

endmodule

// ==== hw/debug_unit.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module debug_unit
    import cpu_pkg::*;
(
    input  logic                           i_clock,
    input  logic                           i_arst_n,
    input  logic                           i_rx_done,
    input  logic [7:0]                     i_rx_data,
    input  logic                           i_tx_done,
    input  logic                           i_hlt,
    input  logic [`DWORD-1:0]              i_pc,
    input  logic [`DWORD-1:0]              i_reg_data,
    input  logic [`DWORD-1:0]              i_mem_data,
    output logic                           o_tx_start,
    output logic [7:0]                     o_tx_data,
    output logic                           o_cpu_en,
    output logic                           o_clear,
    output logic                           o_im_we,
    output logic [$clog2(`IMEM_WORDS)-1:0] o_im_addr,
    output logic [`DWORD-1:0]              o_im_data,
    output logic [$clog2(`REG_COUNT)-1:0]  o_reg_addr,
    output logic [$clog2(`DMEM_WORDS)-1:0] o_mem_addr,
    output du_state_e                      o_state
);
    localparam int DUMP_BYTES = 4 * (1 + `REG_COUNT + `DMEM_WORDS);
    localparam int NB_DCNT    = $clog2(DUMP_BYTES);
    localparam int NB_WIDX    = NB_DCNT - 2;
    localparam int RF_AW      = $clog2(`REG_COUNT);
    localparam int DM_AW      = $clog2(`DMEM_WORDS);

    du_state_e          state;
    logic [7:0]         words_left;
    logic [1:0]         byte_sel;
    logic [`DWORD-1:0]  word_q;
    logic               step_req;  // Step byte seen last cycle
    logic               step_en;
    logic               tx_busy;   // Byte out, waiting for done
    logic [NB_DCNT-1:0] dump_cnt;
    logic [NB_WIDX-1:0] word_idx;
    logic [NB_WIDX-1:0] reg_idx;
    logic [NB_WIDX-1:0] mem_idx;
    logic [`DWORD-1:0]  dump_word;

    // Dump order: PC, registers, data memory
    assign word_idx   = dump_cnt[NB_DCNT-1:2];
    assign reg_idx    = word_idx - NB_WIDX'(1);
    assign mem_idx    = word_idx - NB_WIDX'(1 + `REG_COUNT);
    assign o_reg_addr = reg_idx[RF_AW-1:0];
    assign o_mem_addr = mem_idx[DM_AW-1:0];

    always_comb begin
        if (word_idx == '0) begin
            dump_word = i_pc;
        end else if (word_idx <= NB_WIDX'(`REG_COUNT)) begin
            dump_word = i_reg_data;
        end else begin
            dump_word = i_mem_data;
        end
    end

    assign o_cpu_en  = (step_en || state == RUN) && !i_hlt;
    assign o_im_data = word_q;
    assign o_state   = state;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= IDLE;
            words_left <= '0;
            byte_sel   <= '0;
            word_q     <= '0;
            o_im_addr  <= '0;
            o_im_we    <= 1'b0;
            o_clear    <= 1'b0;
            step_req   <= 1'b0;
            step_en    <= 1'b0;
            tx_busy    <= 1'b0;
            o_tx_start <= 1'b0;
            o_tx_data  <= '0;
            dump_cnt   <= '0;
        end else begin
            o_im_we    <= 1'b0;
            o_clear    <= 1'b0;
            o_tx_start <= 1'b0;
            step_req   <= 1'b0;
            step_en    <= step_req;
            if (o_im_we) begin
                o_im_addr <= o_im_addr + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            `CMD_LOAD: state <= LOAD_COUNT;
                            `CMD_RUN:  state <= RUN;
                            `CMD_STEP: step_req <= 1'b1;
                            `CMD_DUMP: begin
                                state    <= DUMP;
                                dump_cnt <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                LOAD_COUNT: begin
                    if (i_rx_done) begin
                        words_left <= i_rx_data;
                        byte_sel   <= '0;
                        o_im_addr  <= '0;
                        if (i_rx_data == 8'd0) begin
                            state   <= IDLE;
                            o_clear <= 1'b1;
                        end else begin
                            state <= LOAD_BYTES;
                        end
                    end
                end
                LOAD_BYTES: begin
                    if (i_rx_done) begin
                        word_q   <= {word_q[`DWORD-9:0], i_rx_data};  // MSB first
                        byte_sel <= byte_sel + 1'b1;
                        if (byte_sel == 2'd3) begin
                            o_im_we    <= 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == 8'd1) begin
                                state   <= IDLE;
                                o_clear <= 1'b1;
                            end
                        end
                    end
                end
                RUN: begin
                    if (i_hlt) begin
                        state <= IDLE;
                    end
                end
                DUMP: begin
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= dump_word[{~dump_cnt[1:0], 3'b000} +: 8];
                        tx_busy    <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_busy <= 1'b0;
                        if (dump_cnt == NB_DCNT'(DUMP_BYTES - 1)) begin
                            state <= IDLE;
                        end else begin
                            dump_cnt <= dump_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_rx_done,
    input  logic [7:0] i_rx_data,
    output logic       o_tx_start,
    output logic [7:0] o_tx_data,
    output logic       o_hlt,
    output du_state_e  o_state,
    input  logic       i_tx_done
);
    localparam int IM_AW = $clog2(`IMEM_WORDS);
    localparam int RF_AW = $clog2(`REG_COUNT);
    localparam int DM_AW = $clog2(`DMEM_WORDS);

    logic              cpu_en;
    logic              clear;
    logic              im_we;
    logic [IM_AW-1:0]  im_addr;
    logic [`DWORD-1:0] im_data;
    logic [RF_AW-1:0]  dbg_reg_addr;
    logic [DM_AW-1:0]  dbg_mem_addr;
    logic [`DWORD-1:0] dbg_reg_data;
    logic [`DWORD-1:0] dbg_mem_data;
    logic [`DWORD-1:0] pc;
    logic [`DWORD-1:0] next_pc;
    ctrl_t             ctrl;
    exec_t             exec_res;
    wb_t               wb;

    debug_unit u_debug_unit (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx_done  (i_rx_done),
        .i_rx_data  (i_rx_data),
        .i_tx_done  (i_tx_done),
        .i_hlt      (o_hlt),
        .i_pc       (pc),
        .i_reg_data (dbg_reg_data),
        .i_mem_data (dbg_mem_data),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .o_cpu_en   (cpu_en),
        .o_clear    (clear),
        .o_im_we    (im_we),
        .o_im_addr  (im_addr),
        .o_im_data  (im_data),
        .o_reg_addr (dbg_reg_addr),
        .o_mem_addr (dbg_mem_addr),
        .o_state    (o_state)
    );

    instr_decode u_instr_decode (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_cpu_en       (cpu_en),
        .i_clear        (clear),
        .i_im_we        (im_we),
        .i_im_addr      (im_addr),
        .i_im_data      (im_data),
        .i_next_pc      (next_pc),
        .i_wb           (wb),
        .i_dbg_reg_addr (dbg_reg_addr),
        .o_ctrl         (ctrl),
        .o_pc           (pc),
        .o_dbg_reg_data (dbg_reg_data)
    );

    alu_execute u_alu_execute (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_cpu_en  (cpu_en),
        .i_clear   (clear),
        .i_ctrl    (ctrl),
        .i_pc      (pc),
        .o_exec    (exec_res),
        .o_next_pc (next_pc),
        .o_hlt     (o_hlt)
    );

    mem_result u_mem_result (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_cpu_en       (cpu_en),
        .i_clear        (clear),
        .i_exec         (exec_res),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_wb           (wb),
        .o_dbg_mem_data (dbg_mem_data)
    );

endmodule

// ==== bench/cpu_asserts.sv ====
`timescale 1ns/1ns

module cpu_asserts (
    input logic i_clock,
    input logic i_arst_n,
    input logic i_tx_start,
    input logic i_tx_done,
    input logic i_cpu_en,
    input logic i_hlt,
    input logic i_clear
);
    logic pending;  // Byte sent, done not seen yet

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending <= 1'b0;
        end else if (i_tx_start) begin
            pending <= 1'b1;
        end else if (i_tx_done) begin
            pending <= 1'b0;
        end
    end

    a_one_byte_in_flight: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_tx_start |-> !pending)
        else $error("tx_start raised while a byte still waits for tx_done");

    a_no_exec_when_halted: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !(i_cpu_en && i_hlt))
        else $error("cpu_en high while halted");

    // First edge after reset release
    a_tx_quiet_after_reset: assert property (@(posedge i_clock)
        $rose(i_arst_n) |-> !i_tx_start)
        else $error("tx_start high right after reset");

    a_hlt_cleared_by_load: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $fell(i_hlt) |-> $past(i_clear))
        else $error("halt flag dropped without a load");

endmodule

bind debug_unit cpu_asserts u_du_asserts (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_tx_start (o_tx_start),
    .i_tx_done  (i_tx_done),
    .i_cpu_en   (o_cpu_en),
    .i_hlt      (i_hlt),
    .i_clear    (o_clear)
);

bind cpu_top cpu_asserts u_top_asserts (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_tx_start (o_tx_start),
    .i_tx_done  (i_tx_done),
    .i_cpu_en   (cpu_en),
    .i_hlt      (o_hlt),
    .i_clear    (clear)
);

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_tb
    import cpu_pkg::*;
();
    localparam int CLK_PERIOD  = 10;
    localparam int DUMP_WORDS  = 1 + `REG_COUNT + `DMEM_WORDS;
    localparam int DUMP_BYTES  = 4 * DUMP_WORDS;
    localparam int NUM_DUMPS   = 8;
    localparam int MAX_INSTR   = 1000;
    localparam int LOAD_CYCLES = 2 * (2 + 4 * `IMEM_WORDS);
    localparam int RUN_CYCLES  = 4 * `IMEM_WORDS;
    // Up to 11 cycles per dump byte with the slowest tx_done
    localparam int WATCHDOG_CYCLES = NUM_DUMPS * DUMP_BYTES * 12 + 2 * LOAD_CYCLES
                                   + 3 * RUN_CYCLES + 500;

    typedef struct packed {
        logic                               halted;
        logic [`DWORD-1:0]                  pc;
        logic [`REG_COUNT-1:0][`DWORD-1:0]  regs;
        logic [`DMEM_WORDS-1:0][`DWORD-1:0] mem;
    } arch_state_t;

    logic       i_clock   = 1'b0;
    logic       i_arst_n;
    logic       i_rx_done;
    logic [7:0] i_rx_data;
    logic       i_tx_done = 1'b0;
    logic       o_tx_start;
    logic [7:0] o_tx_data;
    logic       o_hlt;
    du_state_e  o_state;

    logic [`DWORD-1:0] prog [`IMEM_WORDS];
    int                prog_len;
    logic [31:0]       tx_rng   = 32'd4;
    logic [31:0]       prog_rng = 32'd4;
    logic [7:0]        rx_bytes [$];
    int                rx_base       = 0;
    int                dumps_req     = 0;
    int                dumps_checked = 0;
    arch_state_t       exp_state;

    cpu_top u_dut (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx_done  (i_rx_done),
        .i_rx_data  (i_rx_data),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .o_hlt      (o_hlt),
        .o_state    (o_state),
        .i_tx_done  (i_tx_done)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pick_funct(input logic [3:0] sel);
        case (sel % 6)
            0:       return `FN_ADDU;
            1:       return `FN_SUBU;
            2:       return `FN_AND;
            3:       return `FN_OR;
            4:       return `FN_XOR;
            default: return `FN_SLT;
        endcase
    endfunction

    // ISA model that stops after max_instr instructions or at halt
    function automatic arch_state_t ref_model(input int max_instr);
        arch_state_t       s;
        logic [`DWORD-1:0] ir;
        logic [`DWORD-1:0] a;
        logic [`DWORD-1:0] b;
        logic [`DWORD-1:0] imm;
        logic [`DWORD-1:0] sum;
        logic [`DWORD-1:0] res;
        int                rs;
        int                rt;
        int                rd;
        int                n;
        s = '0;
        n = 0;
        while (n < max_instr && !s.halted) begin
            ir   = prog[s.pc % `IMEM_WORDS];
            rs   = ir[25:21] % `REG_COUNT;
            rt   = ir[20:16] % `REG_COUNT;
            rd   = ir[15:11] % `REG_COUNT;
            a    = s.regs[rs];
            b    = s.regs[rt];
            imm  = {{16{ir[15]}}, ir[15:0]};
            sum  = a + imm;
            s.pc = s.pc + 32'd1;
            case (ir[31:26])
                `OP_RTYPE: begin
                    case (ir[5:0])
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        `FN_XOR:  res = a ^ b;
                        `FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        default:  res = '0;
                    endcase
                    s.regs[rd] = res;
                end
                `OP_ADDIU: s.regs[rt] = sum;
                `OP_LW:    s.regs[rt] = s.mem[sum % `DMEM_WORDS];
                `OP_SW:    s.mem[sum % `DMEM_WORDS] = b;
                `OP_BEQ: begin
                    if (a == b) begin
                        s.pc = s.pc + imm;
                    end
                end
                `OP_HALT: begin
                    s.pc     = s.pc - 32'd1;  // Stays on the halt
                    s.halted = 1'b1;
                end
                default: ;
            endcase
            s.regs[0] = '0;
            n++;
        end
        return s;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_mismatch(input string what);
        stop_on_error($sformatf("Mismatch at %0t ns: %s", $time, what));
    endtask

    task automatic check_pc(input logic [`DWORD-1:0] got, input logic [`DWORD-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("PC is %h, expected %h", got, exp));
        end
    endtask

    task automatic check_reg(input int idx, input logic [`DWORD-1:0] got,
                             input logic [`DWORD-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("r%0d is %h, expected %h", idx, got, exp));
        end
    endtask

    task automatic check_mem(input int idx, input logic [`DWORD-1:0] got,
                             input logic [`DWORD-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("mem[%0d] is %h, expected %h", idx, got, exp));
        end
    endtask

    task automatic check_hlt(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("o_hlt is %b, expected %b", got, exp));
        end
    endtask

    task automatic check_state(input du_state_e got, input du_state_e exp);
        if (got !== exp) begin
            report_mismatch($sformatf("state is %s, expected %s", got.name(), exp.name()));
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge i_clock);
        #1;
        i_rx_done = 1'b1;
        i_rx_data = b;
        @(posedge i_clock);
        #1;
        i_rx_done = 1'b0;
    endtask

    task automatic load_program();
        send_byte(`CMD_LOAD);
        send_byte(8'(prog_len));
        for (int i = 0; i < prog_len; i++) begin
            for (int k = 3; k >= 0; k--) begin
                send_byte(prog[i][8*k +: 8]);  // Big-endian
            end
        end
        repeat (3) @(posedge i_clock);
    endtask

    task automatic step_cpu(input int count);
        repeat (count) begin
            send_byte(`CMD_STEP);
            repeat (2) @(posedge i_clock);
        end
    endtask

    task automatic run_cpu();
        send_byte(`CMD_RUN);
        do begin
            @(posedge i_clock);
        end while (!(o_hlt && o_state == IDLE));
    endtask

    task automatic expect_dump(input arch_state_t exp);
        exp_state = exp;
        send_byte(`CMD_DUMP);
        while (o_state != IDLE) begin
            @(posedge i_clock);
        end
        dumps_req++;
        wait (dumps_checked == dumps_req);
    endtask

    task automatic build_fixed_program();
        prog_len  = 15;
        prog[0]   = encode_i(`OP_ADDIU, 5'd0, 5'd1, 16'd5);
        prog[1]   = encode_i(`OP_ADDIU, 5'd0, 5'd2, 16'hfff9);
        prog[2]   = encode_r(5'd1, 5'd2, 5'd3, `FN_ADDU);
        prog[3]   = encode_r(5'd1, 5'd2, 5'd4, `FN_SUBU);
        prog[4]   = encode_r(5'd1, 5'd2, 5'd5, `FN_AND);
        prog[5]   = encode_r(5'd1, 5'd2, 5'd6, `FN_OR);
        prog[6]   = encode_r(5'd1, 5'd2, 5'd7, `FN_XOR);
        prog[7]   = encode_r(5'd2, 5'd1, 5'd5, `FN_SLT);   // Negative below positive
        prog[8]   = encode_i(`OP_SW, 5'd3, 5'd4, 16'd2);
        prog[9]   = encode_i(`OP_LW, 5'd3, 5'd6, 16'd2);
        prog[10]  = encode_i(`OP_BEQ, 5'd6, 5'd4, 16'd1);  // Taken
        prog[11]  = encode_i(`OP_ADDIU, 5'd0, 5'd7, 16'd99);
        prog[12]  = encode_i(`OP_BEQ, 5'd1, 5'd2, 16'd1);  // Not taken
        prog[13]  = encode_i(`OP_SW, 5'd1, 5'd7, 16'd0);
        prog[14]  = {`OP_HALT, 26'd0};
    endtask

    task automatic build_random_program();
        logic [31:0] r;
        int          max_off;
        prog_len = 24;
        for (int i = 0; i < prog_len - 1; i++) begin
            prog_rng = xorshift32(prog_rng);
            r        = prog_rng;
            case (r % 5)
                0: prog[i] = encode_i(`OP_ADDIU, r[8:4], r[13:9], r[31:16]);
                1: prog[i] = encode_r(r[8:4], r[13:9], r[18:14], pick_funct(r[22:19]));
                2: prog[i] = encode_i(`OP_SW, r[8:4], r[13:9], r[31:16]);
                3: prog[i] = encode_i(`OP_LW, r[8:4], r[13:9], r[31:16]);
                default: begin
                    // Forward only and never past the halt
                    max_off = prog_len - 2 - i;
                    prog[i] = encode_i(`OP_BEQ, r[8:4], r[13:9],
                                       16'(r[31:16] % (max_off + 1)));
                end
            endcase
        end
        prog[prog_len - 1] = {`OP_HALT, 26'd0};
    endtask

    // UART transmit side of the host
    always begin
        int unsigned wait_cycles;
        @(posedge i_clock);
        if (o_tx_start) begin
            rx_bytes.push_back(o_tx_data);
            tx_rng      = xorshift32(tx_rng);
            wait_cycles = 1 + (tx_rng % 8);
            repeat (wait_cycles) @(posedge i_clock);
            #1;
            i_tx_done = 1'b1;
            @(posedge i_clock);
            #1;
            i_tx_done = 1'b0;
        end
    end

    always begin
        logic [`DWORD-1:0] word;
        wait (dumps_checked < dumps_req);
        if (rx_bytes.size() - rx_base != DUMP_BYTES) begin
            stop_on_error($sformatf("Dump returned %0d bytes instead of %0d",
                                    rx_bytes.size() - rx_base, DUMP_BYTES));
        end
        for (int w = 0; w < DUMP_WORDS; w++) begin
            word = {rx_bytes[rx_base + 4*w], rx_bytes[rx_base + 4*w + 1],
                    rx_bytes[rx_base + 4*w + 2], rx_bytes[rx_base + 4*w + 3]};
            if (w == 0) begin
                check_pc(word, exp_state.pc);
            end else if (w <= `REG_COUNT) begin
                check_reg(w - 1, word, exp_state.regs[w - 1]);
            end else begin
                check_mem(w - 1 - `REG_COUNT, word, exp_state.mem[w - 1 - `REG_COUNT]);
            end
        end
        check_hlt(o_hlt, exp_state.halted);
        rx_base = rx_base + DUMP_BYTES;
        dumps_checked++;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("Timeout: the test did not finish in the expected time");
    end

    initial begin
        i_arst_n  = 1'b0;
        i_rx_done = 1'b0;
        i_rx_data = '0;
        build_fixed_program();
        repeat (10) @(posedge i_clock);
        #1;
        i_arst_n = 1'b1;
        check_state(o_state, IDLE);
        check_hlt(o_hlt, 1'b0);

        load_program();
        expect_dump(ref_model(0));
        step_cpu(4);
        expect_dump(ref_model(4));
        step_cpu(3);
        expect_dump(ref_model(7));
        step_cpu(6);
        expect_dump(ref_model(13));
        run_cpu();
        expect_dump(ref_model(MAX_INSTR));

        // Halted core ignores step and run
        step_cpu(2);
        run_cpu();
        expect_dump(ref_model(MAX_INSTR));

        build_random_program();
        load_program();
        check_hlt(o_hlt, 1'b0);
        expect_dump(ref_model(0));
        run_cpu();
        expect_dump(ref_model(MAX_INSTR));

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/mem_result.sv
hw/debug_unit.sv
hw/cpu_top.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
